//--- list.f
+incdir+common
common/ppc_isa_pkg.sv
common/ppc_ooo_pkg.sv
hdl/instruction_decode.sv
hdl/dispatcher.sv
hdl/gp_reg_file.sv
execute/reservation_station.sv
execute/add_sub_unit.sv
execute/log_unit.sv
hdl/write_back_arbiter.sv
hdl/ppc_core.sv
verif/ppc_core_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module ppc_core_tb -f list.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vppc_core_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

//--- verif/ppc_core_tb.sv
`default_nettype none

module ppc_core_tb;
    import ppc_ooo_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int N_ZERO = 8;
    localparam int N_IMM = 8;
    localparam int N_RANDOM = 300;
    localparam int N_DEP = 40;
    localparam int N_BURST = 24;
    localparam int N_TOTAL = N_ZERO + N_IMM + N_RANDOM + N_DEP + N_BURST;
    localparam int TIMEOUT_CYCLES = 40 * N_TOTAL + 200;

    // Logical station tags follow the eight add/subtract tags
    localparam int LOG_TAG_BASE = 8;

    localparam int OP_ADD = 0;
    localparam int OP_SUBF = 1;
    localparam int OP_AND = 2;
    localparam int OP_OR = 3;
    localparam int OP_XOR = 4;
    localparam int OP_ADDI = 5;
    localparam int OP_ANDI = 6;

    logic clk;
    logic rst_n;
    logic instruction_valid;
    logic instruction_ready;
    logic [31:0] instruction;
    logic wb_valid;
    wb_t wb;

    logic [15:0] lfsr_state;
    logic [31:0] gpr_model [32];
    logic [4:0] pending_addr [$];
    logic [31:0] pending_value [$];
    logic pending_log [$];
    int value_errors;
    int other_errors;
    int sent_count;
    int wb_count;
    logic ready_dropped;

    ppc_core DUT (
        .clk(clk),
        .rst_n(rst_n),
        .instruction_valid(instruction_valid),
        .instruction_ready(instruction_ready),
        .instruction(instruction),
        .wb_valid(wb_valid),
        .wb(wb)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------------------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------------------------------
    function automatic logic next_random_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], next_random_bit()};
        end
        return v;
    endfunction

    // Bit 0 is the MSB in PowerPC forms; logical forms put the source in the RT slot
    function automatic logic [31:0] encode_instruction(input int op, input logic [4:0] d,
            input logic [4:0] a, input logic [4:0] b, input logic [15:0] imm);
        logic [31:0] word;
        case (op)
            OP_ADD: word = {6'd31, d, a, b, 10'd266, 1'b0};
            OP_SUBF: word = {6'd31, d, a, b, 10'd40, 1'b0};
            OP_AND: word = {6'd31, a, d, b, 10'd28, 1'b0};
            OP_OR: word = {6'd31, a, d, b, 10'd444, 1'b0};
            OP_XOR: word = {6'd31, a, d, b, 10'd316, 1'b0};
            OP_ANDI: word = {6'd28, a, d, imm};
            default: word = {6'd14, d, a, imm};
        endcase
        return word;
    endfunction

    // Program-order reference model
    task automatic update_model(input int op, input logic [4:0] d, input logic [4:0] a,
            input logic [4:0] b, input logic [15:0] imm);
        logic [31:0] result;
        case (op)
            OP_ADD: result = gpr_model[a] + gpr_model[b];
            OP_SUBF: result = gpr_model[b] - gpr_model[a];
            OP_AND: result = gpr_model[a] & gpr_model[b];
            OP_OR: result = gpr_model[a] | gpr_model[b];
            OP_XOR: result = gpr_model[a] ^ gpr_model[b];
            OP_ANDI: result = gpr_model[a] & {16'h0000, imm};
            default: result = (a == 5'd0 ? 32'd0 : gpr_model[a]) + {{16{imm[15]}}, imm};
        endcase
        gpr_model[d] = result;
        pending_addr.push_back(d);
        pending_value.push_back(result);
        pending_log.push_back(op == OP_AND || op == OP_OR || op == OP_XOR || op == OP_ANDI);
    endtask

    // Called at 1 unit after a rising edge, returns at the same point
    task automatic send_instruction(input int op, input logic [4:0] d, input logic [4:0] a,
            input logic [4:0] b, input logic [15:0] imm);
        logic accepted;
        instruction = encode_instruction(op, d, a, b, imm);
        instruction_valid = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            accepted = instruction_ready;
            if (!accepted) begin
                ready_dropped = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        sent_count++;
        update_model(op, d, a, b, imm);
    endtask

    task automatic send_random(input logic narrow);
        int op;
        logic [4:0] regs [3];
        logic [15:0] imm;
        op = int'(random_bits(3)) % 7;
        for (int i = 0; i < 3; i++) begin
            if (narrow) begin
                regs[i] = 5'(1 + int'(random_bits(2)) % 3);
            end else begin
                regs[i] = 5'(random_bits(3));
            end
        end
        imm = '0;
        if (op == OP_ADDI || op == OP_ANDI) begin
            imm = random_bits(16);
        end
        send_instruction(op, regs[0], regs[1], regs[2], imm);
    endtask

    // One long chain through r1 so the add/subtract station backs up
    task automatic send_burst(input int count);
        int sel;
        int op;
        logic [15:0] imm;
        for (int i = 0; i < count; i++) begin
            sel = int'(random_bits(2)) % 3;
            op = (sel == 0) ? OP_ADD : ((sel == 1) ? OP_SUBF : OP_ADDI);
            imm = '0;
            if (op == OP_ADDI) begin
                imm = random_bits(16);
            end
            send_instruction(op, 5'd1, 5'd1, 5'(random_bits(3)), imm);
        end
    endtask

    task automatic wait_for_drain();
        instruction_valid = 1'b0;
        while (pending_addr.size() != 0) begin
            @(posedge clk);
        end
        #1;
    endtask

    // --------------------------------------------------------------------------
    // Checking
    // --------------------------------------------------------------------------
    task automatic check_write_back(input logic [4:0] addr, input logic [3:0] rs_id,
            input logic [31:0] value);
        int found;
        logic from_log;
        found = -1;
        from_log = int'(rs_id) >= LOG_TAG_BASE;
        for (int i = 0; i < pending_addr.size(); i++) begin
            if (found < 0 && pending_addr[i] == addr && pending_value[i] == value
                    && pending_log[i] == from_log) begin
                found = i;
            end
        end
        assert (found >= 0) else begin
            value_errors++;
            $display("ERROR %0t: write-back r%0d = %h with tag %0d matches no pending result",
                     $time, addr, value, rs_id);
        end
        if (found >= 0) begin
            pending_addr.delete(found);
            pending_value.delete(found);
            pending_log.delete(found);
        end
        wb_count++;
    endtask

    task automatic print_summary();
        $display("Summary: %0d sent, %0d write-backs, %0d value errors, %0d other errors",
                 sent_count, wb_count, value_errors, other_errors);
    endtask

    // Write-back is registered, so mid-cycle is stable
    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            check_write_back(wb.addr, wb.rs_id, wb.value);
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Watchdog expired with %0d results still outstanding", pending_addr.size());
        print_summary();
        $display("Regression failed");
        $finish;
    end

    // --------------------------------------------------------------------------
    // Test sequence
    // --------------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        instruction_valid = 1'b0;
        instruction = '0;
        lfsr_state = 16'd43686;
        value_errors = 0;
        other_errors = 0;
        sent_count = 0;
        wb_count = 0;
        ready_dropped = 1'b0;
        for (int r = 0; r < 32; r++) begin
            gpr_model[r] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        assert (instruction_ready === 1'b1 && wb_valid === 1'b0) else begin
            other_errors++;
            $display("After reset instruction_ready is not high or wb_valid is not low");
        end

        // Registers start at zero
        for (int r = 0; r < N_ZERO; r++) begin
            send_instruction(OP_ADD, 5'(r), 5'(r), 5'(r), 16'h0000);
        end

        // Immediate rules with r0 made nonzero before addi reads it as zero
        send_instruction(OP_ADDI, 5'd1, 5'd0, 5'd0, 16'hFFFB);
        send_instruction(OP_ADDI, 5'd0, 5'd1, 5'd0, 16'h0010);
        send_instruction(OP_ADDI, 5'd2, 5'd0, 5'd0, 16'h0003);
        send_instruction(OP_ANDI, 5'd3, 5'd1, 5'd0, 16'hFFFF);
        send_instruction(OP_ADDI, 5'd4, 5'd2, 5'd0, 16'h8000);
        send_instruction(OP_ADD, 5'd5, 5'd0, 5'd2, 16'h0000);
        send_instruction(OP_ANDI, 5'd6, 5'd4, 5'd0, 16'h8001);
        send_instruction(OP_ADDI, 5'd7, 5'd0, 5'd0, 16'h7FFF);

        for (int i = 0; i < N_RANDOM; i++) begin
            send_random(1'b0);
        end
        for (int i = 0; i < N_DEP; i++) begin
            send_random(1'b1);
        end

        wait_for_drain();
        ready_dropped = 1'b0;
        send_burst(N_BURST);
        assert (ready_dropped) else begin
            other_errors++;
            $display("instruction_ready never dropped during the add/subtract burst");
        end

        wait_for_drain();
        repeat (10) @(posedge clk);
        assert (pending_addr.size() == 0 && wb_count == sent_count) else begin
            other_errors++;
            $display("Write-back count %0d does not match %0d sent instructions",
                     wb_count, sent_count);
        end

        print_summary();
        if (value_errors + other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/ppc_core.sv
`default_nettype none
`include "ppc_settings.svh"

module ppc_core (
    input  logic clk,
    input  logic rst_n,
    input  logic instruction_valid,
    output logic instruction_ready,
    input  logic [0:31] instruction,
    output logic wb_valid,
    output ppc_ooo_pkg::wb_t wb
);
    import ppc_isa_pkg::*;
    import ppc_ooo_pkg::*;

    logic decode_valid;
    logic decode_ready;
    decode_t decode;

    reg_addr_t gpr_read_addr [2];
    operand_t gpr_read [2];
    logic gpr_update_valid;
    reg_addr_t gpr_update_addr;
    rs_id_t gpr_update_rs_id;

    logic as_insert_valid;
    logic as_insert_ready;
    rs_id_t as_free_id;
    add_sub_entry_t as_entry;
    logic log_insert_valid;
    logic log_insert_ready;
    rs_id_t log_free_id;
    log_entry_t log_entry;

    logic as_issue_valid;
    logic as_issue_ready;
    add_sub_entry_t as_issue_entry;
    rs_id_t as_issue_rs_id;
    logic log_issue_valid;
    logic log_issue_ready;
    log_entry_t log_issue_entry;
    rs_id_t log_issue_rs_id;

    logic as_valid;
    logic as_ready;
    wb_t as_result;
    logic log_valid;
    logic log_ready;
    wb_t log_result;

    // --------------------------------------------------------------------------
    // Front end
    // --------------------------------------------------------------------------
    instruction_decode instr_decode (.*);

    dispatcher dispatch (.*);

    gp_reg_file gprs (
        .clk(clk),
        .rst_n(rst_n),
        .read_addr(gpr_read_addr),
        .read(gpr_read),
        .update_valid(gpr_update_valid),
        .update_addr(gpr_update_addr),
        .update_rs_id(gpr_update_rs_id),
        .wb_valid(wb_valid),
        .wb(wb)
    );

    // --------------------------------------------------------------------------
    // Stations and units
    // --------------------------------------------------------------------------
    reservation_station #(
        .payload_t(add_sub_entry_t),
        .RS_OFFSET(0)
    ) as_station (
        .clk(clk),
        .rst_n(rst_n),
        .insert_valid(as_insert_valid),
        .insert_ready(as_insert_ready),
        .free_id(as_free_id),
        .entry(as_entry),
        .issue_valid(as_issue_valid),
        .issue_ready(as_issue_ready),
        .issue_entry(as_issue_entry),
        .issue_rs_id(as_issue_rs_id),
        .wb_valid(wb_valid),
        .wb(wb)
    );

    reservation_station #(
        .payload_t(log_entry_t),
        .RS_OFFSET(`PPC_RS_DEPTH)
    ) log_station (
        .clk(clk),
        .rst_n(rst_n),
        .insert_valid(log_insert_valid),
        .insert_ready(log_insert_ready),
        .free_id(log_free_id),
        .entry(log_entry),
        .issue_valid(log_issue_valid),
        .issue_ready(log_issue_ready),
        .issue_entry(log_issue_entry),
        .issue_rs_id(log_issue_rs_id),
        .wb_valid(wb_valid),
        .wb(wb)
    );

    add_sub_unit add_sub (
        .clk(clk),
        .rst_n(rst_n),
        .issue_valid(as_issue_valid),
        .issue_ready(as_issue_ready),
        .issue_entry(as_issue_entry),
        .issue_rs_id(as_issue_rs_id),
        .result_valid(as_valid),
        .result_ready(as_ready),
        .result(as_result)
    );

    log_unit logic_unit (
        .clk(clk),
        .rst_n(rst_n),
        .issue_valid(log_issue_valid),
        .issue_ready(log_issue_ready),
        .issue_entry(log_issue_entry),
        .issue_rs_id(log_issue_rs_id),
        .result_valid(log_valid),
        .result_ready(log_ready),
        .result(log_result)
    );

    write_back_arbiter arbiter (.*);

endmodule

`default_nettype wire

//--- hdl/write_back_arbiter.sv
`default_nettype none

module write_back_arbiter (
    input  logic clk,
    input  logic rst_n,
    input  logic as_valid,
    output logic as_ready,
    input  ppc_ooo_pkg::wb_t as_result,
    input  logic log_valid,
    output logic log_ready,
    input  ppc_ooo_pkg::wb_t log_result,
    output logic wb_valid,
    output ppc_ooo_pkg::wb_t wb
);
    logic log_first;

    // Priority flips only when both units compete
    assign as_ready = as_valid && (!log_valid || !log_first);
    assign log_ready = log_valid && (!as_valid || log_first);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            log_first <= 1'b0;
        end else begin
            wb_valid <= as_ready || log_ready;
            if (as_valid && log_valid) begin
                log_first <= !log_first;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (log_ready) begin
            wb <= log_result;
        end else if (as_ready) begin
            wb <= as_result;
        end
    end

    // Each tag completes once, so a repeat means a unit result was taken twice
    assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |=> !wb_valid || wb.rs_id != $past(wb.rs_id))
        else $error("write_back_arbiter: tag %0d written back twice in a row", wb.rs_id);

endmodule

`default_nettype wire

//--- execute/log_unit.sv
`default_nettype none

module log_unit (
    input  logic clk,
    input  logic rst_n,
    input  logic issue_valid,
    output logic issue_ready,
    input  ppc_ooo_pkg::log_entry_t issue_entry,
    input  ppc_ooo_pkg::rs_id_t issue_rs_id,
    output logic result_valid,
    input  logic result_ready,
    output ppc_ooo_pkg::wb_t result
);
    import ppc_isa_pkg::*;

    assign issue_ready = !result_valid || result_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else if (issue_ready) begin
            result_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && issue_ready) begin
            result.rs_id <= issue_rs_id;
            result.addr <= issue_entry.result_addr;
            case (issue_entry.op)
                LOG_OR: result.value <= issue_entry.op_a.value | issue_entry.op_b.value;
                LOG_XOR: result.value <= issue_entry.op_a.value ^ issue_entry.op_b.value;
                default: result.value <= issue_entry.op_a.value & issue_entry.op_b.value;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- execute/add_sub_unit.sv
`default_nettype none

module add_sub_unit (
    input  logic clk,
    input  logic rst_n,
    input  logic issue_valid,
    output logic issue_ready,
    input  ppc_ooo_pkg::add_sub_entry_t issue_entry,
    input  ppc_ooo_pkg::rs_id_t issue_rs_id,
    output logic result_valid,
    input  logic result_ready,
    output ppc_ooo_pkg::wb_t result
);
    import ppc_isa_pkg::*;

    assign issue_ready = !result_valid || result_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else if (issue_ready) begin
            result_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && issue_ready) begin
            result.rs_id <= issue_rs_id;
            result.addr <= issue_entry.result_addr;
            // subf computes rb - ra
            if (issue_entry.op == AS_SUB) begin
                result.value <= issue_entry.op_b.value - issue_entry.op_a.value;
            end else begin
                result.value <= issue_entry.op_a.value + issue_entry.op_b.value;
            end
        end
    end

endmodule

`default_nettype wire

//--- execute/reservation_station.sv
`default_nettype none
`include "ppc_settings.svh"

module reservation_station #(
    parameter type payload_t = ppc_ooo_pkg::add_sub_entry_t,
    parameter int RS_OFFSET = 0
) (
    input  logic clk,
    input  logic rst_n,
    input  logic insert_valid,
    output logic insert_ready,
    output ppc_ooo_pkg::rs_id_t free_id,
    input  payload_t entry,
    output logic issue_valid,
    input  logic issue_ready,
    output payload_t issue_entry,
    output ppc_ooo_pkg::rs_id_t issue_rs_id,
    input  logic wb_valid,
    input  ppc_ooo_pkg::wb_t wb
);
    import ppc_ooo_pkg::*;

    localparam int DEPTH = `PPC_RS_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);

    payload_t slot [DEPTH];
    // A slot stays busy until its own result has been broadcast
    logic busy [DEPTH];
    logic issued [DEPTH];
    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] issue_idx;
    logic stale_wait;

    function automatic logic own_tag(rs_id_t t);
        return (t >> IDX_W) == rs_id_t'(RS_OFFSET >> IDX_W);
    endfunction

    function automatic logic tag_live(rs_id_t t);
        return !own_tag(t) || busy[IDX_W'(t)];
    endfunction

    // Lowest index wins, so scan downwards
    always_comb begin
        insert_ready = 1'b0;
        free_idx = '0;
        issue_valid = 1'b0;
        issue_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                insert_ready = 1'b1;
                free_idx = IDX_W'(i);
            end
            if (busy[i] && !issued[i] && slot[i].op_a.valid && slot[i].op_b.valid) begin
                issue_valid = 1'b1;
                issue_idx = IDX_W'(i);
            end
        end
    end

    assign free_id = rs_id_t'(RS_OFFSET + int'(free_idx));
    assign issue_rs_id = rs_id_t'(RS_OFFSET + int'(issue_idx));
    assign issue_entry = slot[issue_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                busy[i] <= 1'b0;
                issued[i] <= 1'b0;
            end
        end else begin
            if (issue_valid && issue_ready) begin
                issued[issue_idx] <= 1'b1;
            end
            if (wb_valid && own_tag(wb.rs_id)) begin
                busy[IDX_W'(wb.rs_id)] <= 1'b0;
            end
            if (insert_valid && insert_ready) begin
                busy[free_idx] <= 1'b1;
                issued[free_idx] <= 1'b0;
            end
        end
    end

    // Operand wake-up from the broadcast
    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (wb_valid && !slot[i].op_a.valid && slot[i].op_a.rs_id == wb.rs_id) begin
                slot[i].op_a.value <= wb.value;
                slot[i].op_a.valid <= 1'b1;
            end
            if (wb_valid && !slot[i].op_b.valid && slot[i].op_b.rs_id == wb.rs_id) begin
                slot[i].op_b.value <= wb.value;
                slot[i].op_b.valid <= 1'b1;
            end
        end
        if (insert_valid && insert_ready) begin
            slot[free_idx] <= entry;
        end
    end

    always_comb begin
        stale_wait = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (busy[i] && !slot[i].op_a.valid && !tag_live(slot[i].op_a.rs_id)) begin
                stale_wait = 1'b1;
            end
            if (busy[i] && !slot[i].op_b.valid && !tag_live(slot[i].op_b.rs_id)) begin
                stale_wait = 1'b1;
            end
        end
    end

    // Waiting operands only name tags that are still allocated
    assert property (@(posedge clk) disable iff (!rst_n) !stale_wait)
        else $error("reservation_station %0d: operand waits on a released tag", RS_OFFSET);

endmodule

`default_nettype wire

//--- hdl/gp_reg_file.sv
`default_nettype none
`include "ppc_settings.svh"

module gp_reg_file (
    input  logic clk,
    input  logic rst_n,
    input  ppc_isa_pkg::reg_addr_t read_addr [2],
    output ppc_ooo_pkg::operand_t read [2],
    input  logic update_valid,
    input  ppc_isa_pkg::reg_addr_t update_addr,
    input  ppc_ooo_pkg::rs_id_t update_rs_id,
    input  logic wb_valid,
    input  ppc_ooo_pkg::wb_t wb
);
    import ppc_ooo_pkg::*;

    data_t value [`PPC_GPR_COUNT];
    logic valid [`PPC_GPR_COUNT];
    rs_id_t tag [`PPC_GPR_COUNT];
    logic wb_match;

    // Only the newest rename of a register may complete it
    assign wb_match = wb_valid && wb.rs_id == tag[wb.addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `PPC_GPR_COUNT; i++) begin
                value[i] <= '0;
                valid[i] <= 1'b1;
                tag[i] <= '0;
            end
        end else begin
            if (wb_match) begin
                value[wb.addr] <= wb.value;
                valid[wb.addr] <= 1'b1;
            end
            if (update_valid) begin
                valid[update_addr] <= 1'b0;
                tag[update_addr] <= update_rs_id;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            read[p].value = value[read_addr[p]];
            read[p].valid = valid[read_addr[p]];
            read[p].rs_id = tag[read_addr[p]];
            if (!valid[read_addr[p]] && wb_match && wb.addr == read_addr[p]) begin
                read[p].value = wb.value;
                read[p].valid = 1'b1;
            end
        end
    end

    // A rename never hands out a tag whose result is on the bus
    assert property (@(posedge clk) disable iff (!rst_n)
        update_valid && wb_valid && update_addr == wb.addr |-> update_rs_id != wb.rs_id)
        else $error("gp_reg_file: r%0d renamed to tag %0d during its write-back",
                    update_addr, update_rs_id);

endmodule

`default_nettype wire

//--- hdl/dispatcher.sv
`default_nettype none

module dispatcher (
    input  logic decode_valid,
    output logic decode_ready,
    input  ppc_isa_pkg::decode_t decode,
    output ppc_isa_pkg::reg_addr_t gpr_read_addr [2],
    input  ppc_ooo_pkg::operand_t gpr_read [2],
    output logic gpr_update_valid,
    output ppc_isa_pkg::reg_addr_t gpr_update_addr,
    output ppc_ooo_pkg::rs_id_t gpr_update_rs_id,
    output logic as_insert_valid,
    input  logic as_insert_ready,
    input  ppc_ooo_pkg::rs_id_t as_free_id,
    output ppc_ooo_pkg::add_sub_entry_t as_entry,
    output logic log_insert_valid,
    input  logic log_insert_ready,
    input  ppc_ooo_pkg::rs_id_t log_free_id,
    output ppc_ooo_pkg::log_entry_t log_entry
);
    import ppc_isa_pkg::*;
    import ppc_ooo_pkg::*;

    operand_t op_a;
    operand_t op_b;
    logic to_log;

    assign gpr_read_addr[0] = decode.ra_addr;
    assign gpr_read_addr[1] = decode.rb_addr;
    assign to_log = decode.unit == UNIT_LOG;

    always_comb begin
        op_a = gpr_read[0];
        op_b = gpr_read[1];
        // addi with ra 0 adds to zero instead of r0
        if (decode.ra_zero) begin
            op_a = '{value: '0, valid: 1'b1, rs_id: '0};
        end
        if (decode.use_imm) begin
            op_b = '{value: decode.imm, valid: 1'b1, rs_id: '0};
        end
    end

    assign decode_ready = to_log ? log_insert_ready : as_insert_ready;
    assign as_insert_valid = decode_valid && !to_log;
    assign log_insert_valid = decode_valid && to_log;

    assign as_entry = '{op_a: op_a, op_b: op_b, result_addr: decode.result_addr,
                        op: decode.add_sub_op};
    assign log_entry = '{op_a: op_a, op_b: op_b, result_addr: decode.result_addr,
                         op: decode.log_op};

    // Destination is renamed to the slot the instruction lands in
    assign gpr_update_valid = decode_valid && decode_ready;
    assign gpr_update_addr = decode.result_addr;
    assign gpr_update_rs_id = to_log ? log_free_id : as_free_id;

endmodule

`default_nettype wire

//--- hdl/instruction_decode.sv
`default_nettype none
`include "ppc_settings.svh"

module instruction_decode (
    input  logic clk,
    input  logic rst_n,
    input  logic instruction_valid,
    output logic instruction_ready,
    input  logic [0:31] instruction,
    output logic decode_valid,
    input  logic decode_ready,
    output ppc_isa_pkg::decode_t decode
);
    import ppc_isa_pkg::*;

    opcode_t opcode;
    xo_t xo;
    logic known;
    decode_t next;

    assign opcode = instruction[0:5];
    assign xo = instruction[21:30];
    assign instruction_ready = !decode_valid || decode_ready;

    always_comb begin
        next = '0;
        known = 1'b1;
        next.result_addr = instruction[6:10];
        next.ra_addr = instruction[11:15];
        next.rb_addr = instruction[16:20];
        case (opcode)
            OPC_ADDI: begin
                next.unit = UNIT_ADD_SUB;
                next.add_sub_op = AS_ADD;
                next.use_imm = 1'b1;
                next.imm = {{(`PPC_DATA_WIDTH-16){instruction[16]}}, instruction[16:31]};
                next.ra_zero = instruction[11:15] == 5'd0;
            end
            OPC_ANDI: begin
                // Logical forms write RA and read RS
                next.unit = UNIT_LOG;
                next.log_op = LOG_AND;
                next.result_addr = instruction[11:15];
                next.ra_addr = instruction[6:10];
                next.use_imm = 1'b1;
                next.imm = {{(`PPC_DATA_WIDTH-16){1'b0}}, instruction[16:31]};
            end
            OPC_XFORM: begin
                if (xo == XO_ADD || xo == XO_SUBF) begin
                    next.unit = UNIT_ADD_SUB;
                    next.add_sub_op = (xo == XO_SUBF) ? AS_SUB : AS_ADD;
                end else begin
                    next.unit = UNIT_LOG;
                    next.result_addr = instruction[11:15];
                    next.ra_addr = instruction[6:10];
                    case (xo)
                        XO_AND: next.log_op = LOG_AND;
                        XO_OR: next.log_op = LOG_OR;
                        XO_XOR: next.log_op = LOG_XOR;
                        default: known = 1'b0;
                    endcase
                end
            end
            default: known = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            decode_valid <= 1'b0;
        end else if (instruction_ready) begin
            decode_valid <= instruction_valid && known;
        end
    end

    always_ff @(posedge clk) begin
        if (instruction_valid && instruction_ready) begin
            decode <= next;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        instruction_valid && instruction_ready |-> known)
        else $error("instruction_decode: unknown opcode %0d dropped", opcode);

endmodule

`default_nettype wire

//--- common/ppc_ooo_pkg.sv
`default_nettype none
`include "ppc_settings.svh"

package ppc_ooo_pkg;

    typedef logic [0:`PPC_RS_ID_WIDTH-1] rs_id_t;
    typedef logic [0:`PPC_DATA_WIDTH-1] data_t;

    // Value is only meaningful once valid, otherwise rs_id names the producer
    typedef struct packed {
        data_t value;
        logic valid;
        rs_id_t rs_id;
    } operand_t;

    typedef struct packed {
        rs_id_t rs_id;
        ppc_isa_pkg::reg_addr_t addr;
        data_t value;
    } wb_t;

    typedef struct packed {
        operand_t op_a;
        operand_t op_b;
        ppc_isa_pkg::reg_addr_t result_addr;
        ppc_isa_pkg::add_sub_op_t op;
    } add_sub_entry_t;

    typedef struct packed {
        operand_t op_a;
        operand_t op_b;
        ppc_isa_pkg::reg_addr_t result_addr;
        ppc_isa_pkg::log_op_t op;
    } log_entry_t;

endpackage

`default_nettype wire

//--- common/ppc_isa_pkg.sv
`default_nettype none
`include "ppc_settings.svh"

package ppc_isa_pkg;

    typedef logic [0:$clog2(`PPC_GPR_COUNT)-1] reg_addr_t;
    typedef logic [0:5] opcode_t;
    typedef logic [0:9] xo_t;

    localparam opcode_t OPC_ADDI = 6'd14;
    localparam opcode_t OPC_ANDI = 6'd28;
    localparam opcode_t OPC_XFORM = 6'd31;

    // Extended opcodes in bits 21 to 30 with OE clear for add and subf
    localparam xo_t XO_ADD = 10'd266;
    localparam xo_t XO_SUBF = 10'd40;
    localparam xo_t XO_AND = 10'd28;
    localparam xo_t XO_OR = 10'd444;
    localparam xo_t XO_XOR = 10'd316;

    typedef enum logic {AS_ADD, AS_SUB} add_sub_op_t;
    typedef enum logic [1:0] {LOG_AND, LOG_OR, LOG_XOR} log_op_t;
    typedef enum logic {UNIT_ADD_SUB, UNIT_LOG} unit_t;

    typedef struct packed {
        unit_t unit;
        reg_addr_t result_addr;
        reg_addr_t ra_addr;
        reg_addr_t rb_addr;
        logic use_imm;
        logic [0:`PPC_DATA_WIDTH-1] imm;
        logic ra_zero;
        add_sub_op_t add_sub_op;
        log_op_t log_op;
    } decode_t;

endpackage

`default_nettype wire

//--- common/ppc_settings.svh
`ifndef PPC_SETTINGS_SVH
`define PPC_SETTINGS_SVH

// Datapath and register file
`define PPC_DATA_WIDTH 32
`define PPC_GPR_COUNT 32

// Renaming and reservation stations
`define PPC_RS_ID_WIDTH 4
`define PPC_RS_DEPTH 8

`endif
